//--- compile.f
rtl/ooo_pkg.sv
rtl/fetch_predictor.sv
rtl/instruction_queue.sv
rtl/inst_decoder.sv
rtl/cpu_frontend.sv
dv/frontend_checker.sv
dv/tb_frontend.sv

//--- dv/frontend_checker.sv
// **************************************************
// dispatch and cache port monitor for the testbench
// checks order, prediction, decode, stall stability
// and the cache read protocol, and counts errors
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module frontend_checker (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  ooo_pkg::word_t       pc_correct_i,
    input  logic                 mem_read_i,
    input  ooo_pkg::word_t       mem_address_i,
    input  logic                 mem_resp_i,
    input  logic                 dispatch_ready_i,
    input  logic                 dispatch_valid_i,
    input  ooo_pkg::word_t       dispatch_pc_i,
    input  ooo_pkg::word_t       dispatch_pc_next_i,
    input  ooo_pkg::word_t       dispatch_inst_i,
    input  ooo_pkg::op_class_t   dispatch_op_i,
    input  ooo_pkg::reg_idx_t    dispatch_rd_i,
    input  ooo_pkg::reg_idx_t    dispatch_rs1_i,
    input  ooo_pkg::reg_idx_t    dispatch_rs2_i,
    input  ooo_pkg::word_t       dispatch_imm_i,
    input  logic                 dispatch_br_pred_i,
    output int                   error_count_o,
    output int                   dispatch_count_o
);

    localparam int BUNDLE_W = 4 * 32 + 4 + 3 * 5 + 1;

    ooo_pkg::word_t      exp_pc;
    logic                stalled;
    logic [BUNDLE_W-1:0] held_bundle;
    logic [BUNDLE_W-1:0] bundle;
    logic                read_open;
    ooo_pkg::word_t      read_addr;

    assign bundle = {dispatch_pc_i, dispatch_pc_next_i, dispatch_inst_i, dispatch_imm_i,
                     dispatch_op_i, dispatch_rd_i, dispatch_rs1_i, dispatch_rs2_i,
                     dispatch_br_pred_i};

    // jal taken, backward branch taken, everything else falls through
    function automatic logic [32:0] predict_next(input ooo_pkg::word_t pc,
                                                 input ooo_pkg::word_t inst);
        logic signed [20:0] j_off;
        logic signed [12:0] b_off;
        j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (inst[6:0] == ooo_pkg::OPC_JAL) begin
            return {1'b1, pc + 32'(j_off)};
        end
        if (inst[6:0] == ooo_pkg::OPC_BRANCH && b_off < 0) begin
            return {1'b1, pc + 32'(b_off)};
        end
        return {1'b0, pc + 32'd4};
    endfunction

    function automatic void decode_ref(input ooo_pkg::word_t inst,
                                       output ooo_pkg::op_class_t op,
                                       output ooo_pkg::reg_idx_t rd,
                                       output ooo_pkg::reg_idx_t rs1,
                                       output ooo_pkg::reg_idx_t rs2,
                                       output ooo_pkg::word_t imm);
        logic signed [11:0] i_off;
        logic signed [11:0] s_off;
        logic signed [12:0] b_off;
        logic signed [20:0] j_off;
        logic [2:0]         regs;
        i_off = inst[31:20];
        s_off = {inst[31:25], inst[11:7]};
        b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        op    = ooo_pkg::ILLEGAL;
        imm   = '0;
        // rd, rs1, rs2 in use
        regs  = 3'b000;
        case (inst[6:0])
            ooo_pkg::OPC_LUI, ooo_pkg::OPC_AUIPC: begin
                op   = (inst[5]) ? ooo_pkg::LUI : ooo_pkg::AUIPC;
                imm  = {inst[31:12], 12'h000};
                regs = 3'b100;
            end
            ooo_pkg::OPC_JAL: begin
                op   = ooo_pkg::JAL;
                imm  = 32'(j_off);
                regs = 3'b100;
            end
            ooo_pkg::OPC_JALR, ooo_pkg::OPC_LOAD, ooo_pkg::OPC_IMM: begin
                op   = (inst[6:0] == ooo_pkg::OPC_JALR) ? ooo_pkg::JALR
                     : (inst[6:0] == ooo_pkg::OPC_LOAD) ? ooo_pkg::LOAD : ooo_pkg::ALU;
                imm  = 32'(i_off);
                regs = 3'b110;
            end
            ooo_pkg::OPC_BRANCH: begin
                op   = ooo_pkg::BRANCH;
                imm  = 32'(b_off);
                regs = 3'b011;
            end
            ooo_pkg::OPC_STORE: begin
                op   = ooo_pkg::STORE;
                imm  = 32'(s_off);
                regs = 3'b011;
            end
            ooo_pkg::OPC_REG: begin
                op   = ooo_pkg::ALU;
                regs = 3'b111;
            end
            default: op = ooo_pkg::ILLEGAL;
        endcase
        rd  = regs[2] ? inst[11:7]  : 5'd0;
        rs1 = regs[1] ? inst[19:15] : 5'd0;
        rs2 = regs[0] ? inst[24:20] : 5'd0;
    endfunction

    task automatic check_field(input string name, input ooo_pkg::word_t got,
                               input ooo_pkg::word_t exp);
        if (got !== exp) begin
            error_count_o++;
            $display("Fail %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // sampled mid-cycle while all inputs are stable
    always @(negedge clk) begin
        logic [32:0]        pred;
        ooo_pkg::op_class_t op;
        ooo_pkg::reg_idx_t  rd;
        ooo_pkg::reg_idx_t  rs1;
        ooo_pkg::reg_idx_t  rs2;
        ooo_pkg::word_t     imm;
        if (reset_i) begin
            exp_pc    = ooo_pkg::RESET_PC;
            stalled   = 1'b0;
            read_open = 1'b0;
            if (mem_read_i || dispatch_valid_i) begin
                error_count_o++;
                $display("Fail %0t ns: cache read or dispatch active during reset", $time);
            end
        end else begin
            // an open read keeps its address until the response
            if (read_open && (!mem_read_i || mem_address_i !== read_addr)) begin
                error_count_o++;
                $display("Fail %0t ns: cache read dropped or moved before its response",
                         $time);
            end
            read_open = mem_read_i && !mem_resp_i;
            read_addr = mem_address_i;
            if (stalled && (!dispatch_valid_i || bundle !== held_bundle)) begin
                error_count_o++;
                $display("Fail %0t ns: dispatch outputs changed under back-pressure", $time);
            end
            if (dispatch_valid_i && dispatch_ready_i) begin
                dispatch_count_o++;
                pred = predict_next(dispatch_pc_i, dispatch_inst_i);
                decode_ref(dispatch_inst_i, op, rd, rs1, rs2, imm);
                check_field("pc", dispatch_pc_i, exp_pc);
                check_field("inst", dispatch_inst_i, tb_frontend.imem[dispatch_pc_i[9:2]]);
                check_field("pc_next", dispatch_pc_next_i, pred[31:0]);
                check_field("br_pred", 32'(dispatch_br_pred_i), 32'(pred[32]));
                check_field("op", 32'(dispatch_op_i), 32'(op));
                check_field("rd", 32'(dispatch_rd_i), 32'(rd));
                check_field("rs1", 32'(dispatch_rs1_i), 32'(rs1));
                check_field("rs2", 32'(dispatch_rs2_i), 32'(rs2));
                check_field("imm", dispatch_imm_i, imm);
                exp_pc = dispatch_pc_next_i;
            end
            // redirect wins over the predicted path
            if (flush_i) begin
                exp_pc = pc_correct_i;
            end
            stalled     = dispatch_valid_i && !dispatch_ready_i && !flush_i;
            held_bundle = bundle;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_frontend.sv
// **************************************************
// testbench for the RV32I front end
// random instruction memory with 1 to 4 cycle latency,
// random dispatch back-pressure and flush redirects
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

    localparam int NUM_DISPATCH   = 400;
    localparam int TIMEOUT_CYCLES = NUM_DISPATCH * (4 + ooo_pkg::IQ_DEPTH) * 4;

    logic               clk;
    logic               reset;
    logic               flush;
    ooo_pkg::word_t     pc_correct;
    logic               mem_resp;
    ooo_pkg::word_t     mem_rdata;
    logic               mem_read;
    ooo_pkg::word_t     mem_address;
    logic               dispatch_ready;
    logic               dispatch_valid;
    ooo_pkg::word_t     dispatch_pc;
    ooo_pkg::word_t     dispatch_pc_next;
    ooo_pkg::word_t     dispatch_inst;
    ooo_pkg::op_class_t dispatch_op;
    ooo_pkg::reg_idx_t  dispatch_rd;
    ooo_pkg::reg_idx_t  dispatch_rs1;
    ooo_pkg::reg_idx_t  dispatch_rs2;
    ooo_pkg::word_t     dispatch_imm;
    logic               dispatch_br_pred;
    int                 error_count;
    int                 dispatch_count;

    ooo_pkg::word_t     imem [256];
    integer             seed;
    logic               mem_busy;
    int                 mem_wait;
    int                 flush_gap;
    int                 cycles;

    cpu_frontend dut (
        .clk                (clk),
        .reset_i            (reset),
        .flush_i            (flush),
        .pc_correct_i       (pc_correct),
        .mem_resp_i         (mem_resp),
        .mem_rdata_i        (mem_rdata),
        .mem_read_o         (mem_read),
        .mem_address_o      (mem_address),
        .dispatch_ready_i   (dispatch_ready),
        .dispatch_valid_o   (dispatch_valid),
        .dispatch_pc_o      (dispatch_pc),
        .dispatch_pc_next_o (dispatch_pc_next),
        .dispatch_inst_o    (dispatch_inst),
        .dispatch_op_o      (dispatch_op),
        .dispatch_rd_o      (dispatch_rd),
        .dispatch_rs1_o     (dispatch_rs1),
        .dispatch_rs2_o     (dispatch_rs2),
        .dispatch_imm_o     (dispatch_imm),
        .dispatch_br_pred_o (dispatch_br_pred)
    );

    frontend_checker scoreboard (
        .clk                (clk),
        .reset_i            (reset),
        .flush_i            (flush),
        .pc_correct_i       (pc_correct),
        .mem_read_i         (mem_read),
        .mem_address_i      (mem_address),
        .mem_resp_i         (mem_resp),
        .dispatch_ready_i   (dispatch_ready),
        .dispatch_valid_i   (dispatch_valid),
        .dispatch_pc_i      (dispatch_pc),
        .dispatch_pc_next_i (dispatch_pc_next),
        .dispatch_inst_i    (dispatch_inst),
        .dispatch_op_i      (dispatch_op),
        .dispatch_rd_i      (dispatch_rd),
        .dispatch_rs1_i     (dispatch_rs1),
        .dispatch_rs2_i     (dispatch_rs2),
        .dispatch_imm_i     (dispatch_imm),
        .dispatch_br_pred_i (dispatch_br_pred),
        .error_count_o      (error_count),
        .dispatch_count_o   (dispatch_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic ooo_pkg::word_t branch_word(input int off, input ooo_pkg::word_t r);
        logic [12:0] b;
        b = off[12:0];
        return {b[12], b[10:5], r[24:20], r[19:15], r[14:12], b[4:1], b[11],
                ooo_pkg::OPC_BRANCH};
    endfunction

    function automatic ooo_pkg::word_t jal_word(input int off, input ooo_pkg::word_t r);
        logic [20:0] j;
        j = off[20:0];
        return {j[20], j[10:1], j[11], j[19:12], r[11:7], ooo_pkg::OPC_JAL};
    endfunction

    // random mix of classes with short signed jumps so the path stays local
    task automatic fill_memory();
        ooo_pkg::word_t r;
        int             kind;
        int             off;
        for (int a = 0; a < 256; a++) begin
            r    = $random(seed);
            kind = ($random(seed) & 32'h7fff_ffff) % 16;
            case (kind)
                0, 1, 2: imem[a] = {r[31:7], ooo_pkg::OPC_IMM};
                3, 4:    imem[a] = {r[31:7], ooo_pkg::OPC_REG};
                5:       imem[a] = {r[31:7], ooo_pkg::OPC_LUI};
                6:       imem[a] = {r[31:7], ooo_pkg::OPC_AUIPC};
                7:       imem[a] = {r[31:7], ooo_pkg::OPC_LOAD};
                8:       imem[a] = {r[31:7], ooo_pkg::OPC_STORE};
                9, 10, 11: begin
                    off     = (int'(r[30:26]) - 16) * 4;
                    imem[a] = branch_word(off, r);
                end
                12: begin
                    off     = (int'(r[30:25]) - 32) * 4;
                    // no jump onto itself
                    if (off == 0) begin
                        off = 8;
                    end
                    imem[a] = jal_word(off, r);
                end
                13:      imem[a] = {r[31:7], ooo_pkg::OPC_JALR};
                14:      imem[a] = {r[31:7], 7'b0001011};
                default: imem[a] = {r[31:7], 7'b1111111};
            endcase
        end
    endtask

    // one read in flight answered 1 to 4 cycles after it is seen
    task automatic serve_memory();
        mem_resp = 1'b0;
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_resp  = 1'b1;
                mem_rdata = imem[mem_address[9:2]];
                mem_busy  = 1'b0;
            end
        end else if (mem_read) begin
            mem_busy = 1'b1;
            mem_wait = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
        end
    endtask

    // back end model with about 70 percent ready and occasional redirects
    task automatic drive_backend();
        dispatch_ready = (($random(seed) & 32'h7fff_ffff) % 10) < 7;
        flush          = 1'b0;
        if (flush_gap == 0) begin
            flush      = 1'b1;
            pc_correct = $random(seed) & 32'h0000_03fc;
            flush_gap  = 10 + (($random(seed) & 32'h7fff_ffff) % 40);
        end else begin
            flush_gap--;
        end
    endtask

    initial begin
        seed           = 32'hc791ffb4;
        reset          = 1'b1;
        flush          = 1'b0;
        pc_correct     = '0;
        mem_resp       = 1'b0;
        mem_rdata      = '0;
        dispatch_ready = 1'b0;
        mem_busy       = 1'b0;
        mem_wait       = 0;
        flush_gap      = 20;
        cycles         = 0;
        fill_memory();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        while (dispatch_count < NUM_DISPATCH && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            serve_memory();
            drive_backend();
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: only %0d of %0d instructions dispatched in %0d cycles",
                     dispatch_count, NUM_DISPATCH, cycles);
        end
        $display("errors: %0d, dispatches: %0d, cycles: %0d",
                 error_count, dispatch_count, cycles);
        if (error_count == 0 && cycles < TIMEOUT_CYCLES) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cpu_frontend.sv
// **************************************************
// front end top: fetch, instruction queue, decode
// the back end attaches at the dispatch ports
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module cpu_frontend (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  ooo_pkg::word_t       pc_correct_i,
    // instruction cache
    input  logic                 mem_resp_i,
    input  ooo_pkg::word_t       mem_rdata_i,
    output logic                 mem_read_o,
    output ooo_pkg::word_t       mem_address_o,
    // dispatch to back end
    input  logic                 dispatch_ready_i,
    output logic                 dispatch_valid_o,
    output ooo_pkg::word_t       dispatch_pc_o,
    output ooo_pkg::word_t       dispatch_pc_next_o,
    output ooo_pkg::word_t       dispatch_inst_o,
    output ooo_pkg::op_class_t   dispatch_op_o,
    output ooo_pkg::reg_idx_t    dispatch_rd_o,
    output ooo_pkg::reg_idx_t    dispatch_rs1_o,
    output ooo_pkg::reg_idx_t    dispatch_rs2_o,
    output ooo_pkg::word_t       dispatch_imm_o,
    output logic                 dispatch_br_pred_o
);

    logic           iq_valid;
    logic           iq_ready;
    ooo_pkg::word_t iq_pc;
    ooo_pkg::word_t iq_inst;
    ooo_pkg::word_t iq_pc_next;
    logic           iq_br_pred;

    logic           head_valid;
    ooo_pkg::word_t head_pc;
    ooo_pkg::word_t head_pc_next;
    ooo_pkg::word_t head_inst;
    logic           head_br_pred;
    logic           iq_shift;

    fetch_predictor fetch_predictor_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .pc_correct_i  (pc_correct_i),
        .mem_resp_i    (mem_resp_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_read_o    (mem_read_o),
        .mem_address_o (mem_address_o),
        .iq_ready_i    (iq_ready),
        .iq_valid_o    (iq_valid),
        .iq_pc_o       (iq_pc),
        .iq_inst_o     (iq_inst),
        .iq_pc_next_o  (iq_pc_next),
        .iq_br_pred_o  (iq_br_pred)
    );

    instruction_queue instruction_queue_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .push_i         (iq_valid),
        .push_pc_i      (iq_pc),
        .push_inst_i    (iq_inst),
        .push_pc_next_i (iq_pc_next),
        .push_br_pred_i (iq_br_pred),
        .ready_o        (iq_ready),
        .shift_i        (iq_shift),
        .head_valid_o   (head_valid),
        .head_pc_o      (head_pc),
        .head_pc_next_o (head_pc_next),
        .head_inst_o    (head_inst),
        .head_br_pred_o (head_br_pred)
    );

    inst_decoder inst_decoder_inst (
        .head_valid_i       (head_valid),
        .head_pc_i          (head_pc),
        .head_pc_next_i     (head_pc_next),
        .head_inst_i        (head_inst),
        .head_br_pred_i     (head_br_pred),
        .shift_o            (iq_shift),
        .dispatch_ready_i   (dispatch_ready_i),
        .dispatch_valid_o   (dispatch_valid_o),
        .dispatch_pc_o      (dispatch_pc_o),
        .dispatch_pc_next_o (dispatch_pc_next_o),
        .dispatch_inst_o    (dispatch_inst_o),
        .dispatch_op_o      (dispatch_op_o),
        .dispatch_rd_o      (dispatch_rd_o),
        .dispatch_rs1_o     (dispatch_rs1_o),
        .dispatch_rs2_o     (dispatch_rs2_o),
        .dispatch_imm_o     (dispatch_imm_o),
        .dispatch_br_pred_o (dispatch_br_pred_o)
    );

endmodule

`default_nettype wire

//--- rtl/fetch_predictor.sv
// **************************************************
// instruction fetch with a static next-PC predictor
// issues one cache read at a time and pushes each
// returned word into the instruction queue
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  ooo_pkg::word_t       pc_correct_i,
    input  logic                 mem_resp_i,
    input  ooo_pkg::word_t       mem_rdata_i,
    output logic                 mem_read_o,
    output ooo_pkg::word_t       mem_address_o,
    input  logic                 iq_ready_i,
    output logic                 iq_valid_o,
    output ooo_pkg::word_t       iq_pc_o,
    output ooo_pkg::word_t       iq_inst_o,
    output ooo_pkg::word_t       iq_pc_next_o,
    output logic                 iq_br_pred_o
);

    ooo_pkg::fetch_state_t state_q;
    ooo_pkg::fetch_state_t state_d;
    ooo_pkg::word_t        pc_q;
    ooo_pkg::word_t        pc_d;
    ooo_pkg::word_t        redirect_q;
    ooo_pkg::word_t        held_q;
    ooo_pkg::word_t        fetch_word;
    ooo_pkg::word_t        j_imm;
    ooo_pkg::word_t        b_imm;
    ooo_pkg::word_t        pred_next;
    ooo_pkg::opcode_t      opcode;
    logic                  pred_taken;

    // word under consideration, live from the cache or held
    assign fetch_word = (state_q == ooo_pkg::HOLD) ? held_q : mem_rdata_i;
    assign opcode     = fetch_word[6:0];

    assign j_imm = {{12{fetch_word[31]}}, fetch_word[19:12], fetch_word[20],
                    fetch_word[30:21], 1'b0};
    assign b_imm = {{20{fetch_word[31]}}, fetch_word[7], fetch_word[30:25],
                    fetch_word[11:8], 1'b0};

    // jal always taken, branches taken only when backward
    always_comb begin
        pred_taken = 1'b0;
        pred_next  = pc_q + 32'd4;
        if (opcode == ooo_pkg::OPC_JAL) begin
            pred_taken = 1'b1;
            pred_next  = pc_q + j_imm;
        end else if (opcode == ooo_pkg::OPC_BRANCH && fetch_word[31]) begin
            pred_taken = 1'b1;
            pred_next  = pc_q + b_imm;
        end
    end

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            ooo_pkg::IDLE: begin
                state_d = ooo_pkg::WAIT_RESP;
            end
            ooo_pkg::WAIT_RESP: begin
                if (mem_resp_i && !flush_i) begin
                    if (iq_ready_i) begin
                        pc_d = pred_next;
                    end else begin
                        state_d = ooo_pkg::HOLD;
                    end
                end else if (flush_i && !mem_resp_i) begin
                    // read still out, wait for it and drop the data
                    state_d = ooo_pkg::DRAIN;
                end
            end
            ooo_pkg::HOLD: begin
                if (flush_i) begin
                    state_d = ooo_pkg::WAIT_RESP;
                end else if (iq_ready_i) begin
                    state_d = ooo_pkg::WAIT_RESP;
                    pc_d    = pred_next;
                end
            end
            ooo_pkg::DRAIN: begin
                if (mem_resp_i) begin
                    state_d = ooo_pkg::WAIT_RESP;
                    pc_d    = redirect_q;
                end
            end
            default: state_d = ooo_pkg::IDLE;
        endcase
        // address must stay put while draining
        if (flush_i && state_d != ooo_pkg::DRAIN) begin
            pc_d = pc_correct_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ooo_pkg::IDLE;
            pc_q    <= ooo_pkg::RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_i) begin
            redirect_q <= pc_correct_i;
        end
        if (state_q == ooo_pkg::WAIT_RESP && mem_resp_i) begin
            held_q <= mem_rdata_i;
        end
    end

    assign mem_read_o    = (state_q == ooo_pkg::WAIT_RESP) || (state_q == ooo_pkg::DRAIN);
    assign mem_address_o = pc_q;

    assign iq_valid_o   = !flush_i && ((state_q == ooo_pkg::WAIT_RESP && mem_resp_i)
                                       || state_q == ooo_pkg::HOLD);
    assign iq_pc_o      = pc_q;
    assign iq_inst_o    = fetch_word;
    assign iq_pc_next_o = pred_next;
    assign iq_br_pred_o = pred_taken;

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
// **************************************************
// decodes the queue head into a dispatch bundle
// pure logic, pops the queue when dispatch is taken
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                 head_valid_i,
    input  ooo_pkg::word_t       head_pc_i,
    input  ooo_pkg::word_t       head_pc_next_i,
    input  ooo_pkg::word_t       head_inst_i,
    input  logic                 head_br_pred_i,
    output logic                 shift_o,
    input  logic                 dispatch_ready_i,
    output logic                 dispatch_valid_o,
    output ooo_pkg::word_t       dispatch_pc_o,
    output ooo_pkg::word_t       dispatch_pc_next_o,
    output ooo_pkg::word_t       dispatch_inst_o,
    output ooo_pkg::op_class_t   dispatch_op_o,
    output ooo_pkg::reg_idx_t    dispatch_rd_o,
    output ooo_pkg::reg_idx_t    dispatch_rs1_o,
    output ooo_pkg::reg_idx_t    dispatch_rs2_o,
    output ooo_pkg::word_t       dispatch_imm_o,
    output logic                 dispatch_br_pred_o
);

    ooo_pkg::opcode_t opcode;
    ooo_pkg::word_t   imm_i;
    ooo_pkg::word_t   imm_s;
    ooo_pkg::word_t   imm_b;
    ooo_pkg::word_t   imm_u;
    ooo_pkg::word_t   imm_j;
    logic             uses_rd;
    logic             uses_rs1;
    logic             uses_rs2;

    assign opcode = head_inst_i[6:0];

    // sign-extended immediates for each format
    assign imm_i = {{21{head_inst_i[31]}}, head_inst_i[30:20]};
    assign imm_s = {{21{head_inst_i[31]}}, head_inst_i[30:25], head_inst_i[11:7]};
    assign imm_b = {{20{head_inst_i[31]}}, head_inst_i[7], head_inst_i[30:25],
                    head_inst_i[11:8], 1'b0};
    assign imm_u = {head_inst_i[31:12], 12'h000};
    assign imm_j = {{12{head_inst_i[31]}}, head_inst_i[19:12], head_inst_i[20],
                    head_inst_i[30:21], 1'b0};

    always_comb begin
        dispatch_op_o  = ooo_pkg::ILLEGAL;
        dispatch_imm_o = '0;
        uses_rd        = 1'b0;
        uses_rs1       = 1'b0;
        uses_rs2       = 1'b0;
        case (opcode)
            ooo_pkg::OPC_LUI: begin
                dispatch_op_o  = ooo_pkg::LUI;
                dispatch_imm_o = imm_u;
                uses_rd        = 1'b1;
            end
            ooo_pkg::OPC_AUIPC: begin
                dispatch_op_o  = ooo_pkg::AUIPC;
                dispatch_imm_o = imm_u;
                uses_rd        = 1'b1;
            end
            ooo_pkg::OPC_JAL: begin
                dispatch_op_o  = ooo_pkg::JAL;
                dispatch_imm_o = imm_j;
                uses_rd        = 1'b1;
            end
            ooo_pkg::OPC_JALR: begin
                dispatch_op_o  = ooo_pkg::JALR;
                dispatch_imm_o = imm_i;
                uses_rd        = 1'b1;
                uses_rs1       = 1'b1;
            end
            ooo_pkg::OPC_BRANCH: begin
                dispatch_op_o  = ooo_pkg::BRANCH;
                dispatch_imm_o = imm_b;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            ooo_pkg::OPC_LOAD: begin
                dispatch_op_o  = ooo_pkg::LOAD;
                dispatch_imm_o = imm_i;
                uses_rd        = 1'b1;
                uses_rs1       = 1'b1;
            end
            ooo_pkg::OPC_STORE: begin
                dispatch_op_o  = ooo_pkg::STORE;
                dispatch_imm_o = imm_s;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            ooo_pkg::OPC_IMM: begin
                dispatch_op_o  = ooo_pkg::ALU;
                dispatch_imm_o = imm_i;
                uses_rd        = 1'b1;
                uses_rs1       = 1'b1;
            end
            // register-register ALU carries no immediate
            ooo_pkg::OPC_REG: begin
                dispatch_op_o = ooo_pkg::ALU;
                uses_rd       = 1'b1;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
            end
            default: dispatch_op_o = ooo_pkg::ILLEGAL;
        endcase
    end

    // unused register fields read as x0
    assign dispatch_rd_o  = uses_rd  ? head_inst_i[11:7]  : '0;
    assign dispatch_rs1_o = uses_rs1 ? head_inst_i[19:15] : '0;
    assign dispatch_rs2_o = uses_rs2 ? head_inst_i[24:20] : '0;

    assign dispatch_valid_o   = head_valid_i;
    assign dispatch_pc_o      = head_pc_i;
    assign dispatch_pc_next_o = head_pc_next_i;
    assign dispatch_inst_o    = head_inst_i;
    assign dispatch_br_pred_o = head_br_pred_i;

    assign shift_o = head_valid_i && dispatch_ready_i;

endmodule

`default_nettype wire

//--- rtl/instruction_queue.sv
// **************************************************
// circular buffer between fetch and decode
// holds each word with its PC and predicted next PC
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module instruction_queue (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  ooo_pkg::word_t       push_pc_i,
    input  ooo_pkg::word_t       push_inst_i,
    input  ooo_pkg::word_t       push_pc_next_i,
    input  logic                 push_br_pred_i,
    output logic                 ready_o,
    input  logic                 shift_i,
    output logic                 head_valid_o,
    output ooo_pkg::word_t       head_pc_o,
    output ooo_pkg::word_t       head_pc_next_o,
    output ooo_pkg::word_t       head_inst_o,
    output logic                 head_br_pred_o
);

    ooo_pkg::word_t   pc_mem      [ooo_pkg::IQ_DEPTH];
    ooo_pkg::word_t   inst_mem    [ooo_pkg::IQ_DEPTH];
    ooo_pkg::word_t   pc_next_mem [ooo_pkg::IQ_DEPTH];
    logic             pred_mem    [ooo_pkg::IQ_DEPTH];
    ooo_pkg::iq_ptr_t wr_ptr;
    ooo_pkg::iq_ptr_t rd_ptr;
    ooo_pkg::iq_cnt_t count;
    logic             push_en;
    logic             pop_en;

    assign ready_o      = count < ooo_pkg::iq_cnt_t'(ooo_pkg::IQ_DEPTH);
    assign head_valid_o = count != '0;

    assign push_en = push_i && ready_o;
    assign pop_en  = shift_i && head_valid_o;

    // entry storage
    always_ff @(posedge clk) begin
        if (push_en) begin
            pc_mem[wr_ptr]      <= push_pc_i;
            inst_mem[wr_ptr]    <= push_inst_i;
            pc_next_mem[wr_ptr] <= push_pc_next_i;
            pred_mem[wr_ptr]    <= push_br_pred_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_pc_o      = pc_mem[rd_ptr];
    assign head_pc_next_o = pc_next_mem[rd_ptr];
    assign head_inst_o    = inst_mem[rd_ptr];
    assign head_br_pred_o = pred_mem[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/ooo_pkg.sv
// **************************************************
// shared types and constants for the RV32I front end
// used by scoped name from every RTL and DV file
// **************************************************
`default_nettype none

package ooo_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // decoded operation class handed to dispatch
    typedef enum logic [3:0] {
        ALU,
        LUI,
        AUIPC,
        BRANCH,
        JAL,
        JALR,
        LOAD,
        STORE,
        ILLEGAL
    } op_class_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        HOLD,
        DRAIN
    } fetch_state_t;

    // RV32I base opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_REG    = 7'b0110011;

    // instruction queue sizing
    localparam int IQ_DEPTH = 8;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
    typedef logic [IQ_CNT_W-1:0] iq_cnt_t;

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_frontend -o tb_frontend_sim

out=$(./obj_dir/tb_frontend_sim)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qF '** PASS **'
